// File: Bender.yml
package:
  name: mycpu

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - rtl/cpu_isa_pkg.sv
      - rtl/cpu_ctrl_pkg.sv
      - rtl/inst_decoder.sv
      - rtl/reg_file.sv
      - rtl/alu.sv
      - rtl/divu_unit.sv
      - rtl/pipe_ctrl.sv
      - rtl/mycpu_top.sv
  - target: simulation
    files:
      - verif/tb_mycpu.sv

// File: flist.f
rtl/cpu_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/divu_unit.sv
rtl/pipe_ctrl.sv
rtl/mycpu_top.sv
verif/tb_mycpu.sv

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_isa_pkg::word_t    a,
	input  cpu_isa_pkg::word_t    b,
	input  cpu_ctrl_pkg::alu_op_e op,
	output cpu_isa_pkg::word_t    result
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	always_comb
	begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			// compares give 0 or 1
			ALU_SLT:  result = word_t'($signed(a) < $signed(b));
			ALU_SLTU: result = word_t'(a < b);
			// shift b by the amount in a
			ALU_SLL:  result = b << a[4:0];
			ALU_SRL:  result = b >> a[4:0];
			default:  result = '0;
		endcase
	end

endmodule

// File: rtl/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	// alu function picked by the decoder
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL
	} alu_op_e;

	// where the register write value comes from
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_HI,
		WB_LO
	} wb_sel_e;

	// fetch sequencer
	typedef enum logic {
		PIPE_BOOT,
		PIPE_RUN
	} pipe_state_e;

	// divider sequencer
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_BUSY,
		DIV_DONE
	} div_state_e;

endpackage

// File: rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// machine word and register index
	localparam int XLEN = 32;
	typedef logic [XLEN-1:0] word_t;

	localparam int REG_ADDR_W = 5;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// first fetch after reset
	localparam word_t RESET_VECTOR = 32'hbfc0_0000;

	// one quotient bit per divider step
	localparam int DIV_CYCLES = 32;

	// primary opcodes, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// SPECIAL function field, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_MFHI = 6'h10,
		FN_MFLO = 6'h12,
		FN_DIVU = 6'h1b,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

endpackage

// File: rtl/divu_unit.sv
`timescale 1ns/1ps

module divu_unit (
	input  logic               clk,
	input  logic               resetn,
	input  logic               start,
	input  logic               ack,
	input  cpu_isa_pkg::word_t dividend,
	input  cpu_isa_pkg::word_t divisor,
	output logic               done,
	output cpu_isa_pkg::word_t quotient,
	output cpu_isa_pkg::word_t remainder
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	div_state_e      state_q;
	logic [4:0]      cnt_q;
	word_t           rem_q;
	word_t           quo_q;
	word_t           div_q;
	word_t           src_rem;
	word_t           src_quo;
	word_t           src_div;
	logic [XLEN:0]   cand;
	logic            fits;

	// first step runs on the start edge from the raw operands
	assign src_rem = start ? '0 : rem_q;
	assign src_quo = start ? dividend : quo_q;
	assign src_div = start ? divisor : div_q;

	// shift in next dividend bit, subtract if it fits
	// zero divisor always fits, giving all ones and rem = dividend
	assign cand = {src_rem, src_quo[XLEN-1]};
	assign fits = cand >= {1'b0, src_div};

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state_q <= DIV_IDLE;
			cnt_q   <= '0;
		end
		else
		begin
			case (state_q)
				DIV_IDLE:
				begin
					if (start)
						state_q <= DIV_BUSY;
					cnt_q <= '0;
				end
				DIV_BUSY:
				begin
					cnt_q <= cnt_q + 5'd1;
					// start edge did one step, so one fewer here
					if (cnt_q == 5'(DIV_CYCLES - 2))
						state_q <= DIV_DONE;
				end
				DIV_DONE:
				begin
					if (ack)
						state_q <= DIV_IDLE;
				end
				default: state_q <= DIV_IDLE;
			endcase
		end
	end

	// result stays put until the next start
	always_ff @(posedge clk)
	begin
		if (start || state_q == DIV_BUSY)
		begin
			rem_q <= fits ? word_t'(cand - {1'b0, src_div}) : cand[XLEN-1:0];
			quo_q <= {src_quo[XLEN-2:0], fits};
		end
		if (start)
			div_q <= divisor;
	end

	assign done      = (state_q == DIV_DONE);
	assign quotient  = quo_q;
	assign remainder = rem_q;

	// EX issues once per divu and acks only when it leaves EX
	a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
		start |-> state_q == DIV_IDLE);
	a_ack_done: assert property (@(posedge clk) disable iff (!resetn)
		ack |-> state_q == DIV_DONE);

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  cpu_isa_pkg::word_t     inst,
	output cpu_isa_pkg::reg_addr_t rs,
	output cpu_isa_pkg::reg_addr_t rt,
	output cpu_isa_pkg::reg_addr_t rd_dst,
	output cpu_isa_pkg::word_t     imm,
	output logic                   use_imm,
	output logic                   use_shamt,
	output logic                   reg_write,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic                   is_beq,
	output logic                   is_bne,
	output logic                   is_j,
	output logic                   is_divu,
	output cpu_ctrl_pkg::alu_op_e  alu_op,
	output cpu_ctrl_pkg::wb_sel_e  wb_sel
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	opcode_e op;
	funct_e  fn;

	assign op = opcode_e'(inst[31:26]);
	assign fn = funct_e'(inst[5:0]);

	// lui reads r0 so it runs as r0 | (imm << 16)
	assign rs = (op == OP_LUI) ? '0 : inst[25:21];
	assign rt = inst[20:16];

	// immediate forms
	// shifts carry shamt here, andi/ori zero extend, lui goes to the upper half
	always_comb
	begin
		case (op)
			OP_SPECIAL:     imm = {27'b0, inst[10:6]};
			OP_ANDI, OP_ORI: imm = {16'b0, inst[15:0]};
			OP_LUI:         imm = {inst[15:0], 16'b0};
			default:        imm = {{16{inst[15]}}, inst[15:0]};
		endcase
	end

	always_comb
	begin
		// no-op unless an encoding below matches
		rd_dst    = inst[20:16];
		use_imm   = 1'b0;
		use_shamt = 1'b0;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		is_beq    = 1'b0;
		is_bne    = 1'b0;
		is_j      = 1'b0;
		is_divu   = 1'b0;
		alu_op    = ALU_ADD;
		wb_sel    = WB_ALU;
		case (op)
			OP_SPECIAL:
			begin
				rd_dst    = inst[15:11];
				reg_write = 1'b1;
				use_shamt = (fn == FN_SLL) || (fn == FN_SRL);
				case (fn)
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_MFHI: wb_sel = WB_HI;
					FN_MFLO: wb_sel = WB_LO;
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_DIVU:
					begin
						// result goes to HI/LO, not the register file
						reg_write = 1'b0;
						is_divu   = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI:
			begin
				reg_write = 1'b1;
				use_imm   = 1'b1;
				if (op == OP_SLTI)
					alu_op = ALU_SLT;
				else if (op == OP_ANDI)
					alu_op = ALU_AND;
				else if (op != OP_ADDIU)
					alu_op = ALU_OR;
			end
			OP_LW:
			begin
				reg_write = 1'b1;
				use_imm   = 1'b1;
				mem_read  = 1'b1;
				wb_sel    = WB_MEM;
			end
			OP_SW:
			begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			OP_BEQ:  is_beq = 1'b1;
			OP_BNE:  is_bne = 1'b1;
			OP_J:    is_j = 1'b1;
			default: reg_write = 1'b0;
		endcase
	end

endmodule

// File: rtl/mycpu_top.sv
`timescale 1ns/1ps

module mycpu_top (
	input  logic                   resetn,
	input  logic                   clk,
	output cpu_isa_pkg::word_t     inst_sram_addr,
	input  cpu_isa_pkg::word_t     inst_sram_rdata,
	output logic                   data_sram_en,
	output logic [3:0]             data_sram_wen,
	output cpu_isa_pkg::word_t     data_sram_addr,
	output cpu_isa_pkg::word_t     data_sram_wdata,
	input  cpu_isa_pkg::word_t     data_sram_rdata,
	output cpu_isa_pkg::word_t     debug_wb_pc,
	output logic [3:0]             debug_wb_rf_wen,
	output cpu_isa_pkg::reg_addr_t debug_wb_rf_wnum,
	output cpu_isa_pkg::word_t     debug_wb_rf_wdata
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic      ex_valid, mem_valid, id_to_ex, ex_to_mem, ex_ready, redirect;
	word_t     id_pc, id_pc4, id_imm, id_target;
	reg_addr_t id_rs, id_rt, id_rd;
	logic      id_use_imm, id_use_shamt, id_reg_write, id_mem_read, id_mem_write;
	logic      id_is_beq, id_is_bne, id_is_j, id_is_divu;
	alu_op_e   id_alu_op;
	wb_sel_e   id_wb_sel;

	word_t     ex_pc, ex_imm, ex_target;
	reg_addr_t ex_rs, ex_rt, ex_rd;
	logic      ex_use_imm, ex_use_shamt, ex_reg_write, ex_mem_read, ex_mem_write;
	logic      ex_is_beq, ex_is_bne, ex_is_j, ex_is_divu;
	alu_op_e   ex_alu_op;
	wb_sel_e   ex_wb_sel;
	word_t     rs_data, rt_data, rs_fwd, rt_fwd, alu_res, ex_result, hi_fwd, lo_fwd;
	logic      div_start, div_done, div_issued;
	word_t     div_quo, div_rem;

	word_t     mem_pc, mem_result, mem_wdata, hi_q, lo_q;
	reg_addr_t mem_rd;
	logic      mem_reg_write, mem_is_divu, mem_wen;
	wb_sel_e   mem_wb_sel;

	pipe_ctrl u_pipe_ctrl (
		.clk, .resetn, .ex_ready, .redirect,
		.redirect_pc(ex_target),
		.id_valid(), .ex_valid, .mem_valid, .id_to_ex, .ex_to_mem, .id_pc,
		.fetch_addr(inst_sram_addr)
	);

	// ID decodes the word fetched last cycle
	inst_decoder u_dec (
		.inst(inst_sram_rdata), .rs(id_rs), .rt(id_rt), .rd_dst(id_rd), .imm(id_imm),
		.use_imm(id_use_imm), .use_shamt(id_use_shamt), .reg_write(id_reg_write),
		.mem_read(id_mem_read), .mem_write(id_mem_write), .is_beq(id_is_beq),
		.is_bne(id_is_bne), .is_j(id_is_j), .is_divu(id_is_divu),
		.alu_op(id_alu_op), .wb_sel(id_wb_sel)
	);

	// targets are relative to the delay slot
	assign id_pc4    = id_pc + 32'd4;
	assign id_target = id_is_j ? {id_pc4[31:28], inst_sram_rdata[25:0], 2'b00}
	                           : id_pc4 + {id_imm[29:0], 2'b00};

	// ID/EX
	always_ff @(posedge clk)
	begin
		if (id_to_ex)
		begin
			ex_pc        <= id_pc;
			ex_imm       <= id_imm;
			ex_target    <= id_target;
			ex_rs        <= id_rs;
			ex_rt        <= id_rt;
			ex_rd        <= id_rd;
			ex_use_imm   <= id_use_imm;
			ex_use_shamt <= id_use_shamt;
			ex_reg_write <= id_reg_write;
			ex_mem_read  <= id_mem_read;
			ex_mem_write <= id_mem_write;
			ex_is_beq    <= id_is_beq;
			ex_is_bne    <= id_is_bne;
			ex_is_j      <= id_is_j;
			ex_is_divu   <= id_is_divu;
			ex_alu_op    <= id_alu_op;
			ex_wb_sel    <= id_wb_sel;
		end
	end

	// regfile read in EX, written at the end of MEM
	reg_file u_rf (
		.clk, .rs_addr(ex_rs), .rt_addr(ex_rt), .w_addr(mem_rd), .w_en(mem_wen),
		.w_data(mem_wdata), .rs_data, .rt_data
	);

	// bypass from MEM, r0 already excluded by mem_wen
	assign rs_fwd = (mem_wen && mem_rd == ex_rs) ? mem_wdata : rs_data;
	assign rt_fwd = (mem_wen && mem_rd == ex_rt) ? mem_wdata : rt_data;

	alu u_alu (
		.a(ex_use_shamt ? ex_imm : rs_fwd),
		.b(ex_use_imm ? ex_imm : rt_fwd),
		.op(ex_alu_op),
		.result(alu_res)
	);

	// branch resolution
	assign redirect = ex_valid && (ex_is_j || (ex_is_beq && rs_fwd == rt_fwd) ||
	                               (ex_is_bne && rs_fwd != rt_fwd));

	// data SRAM driven straight from EX, full word only
	assign data_sram_en    = ex_valid && (ex_mem_read || ex_mem_write);
	assign data_sram_wen   = {4{ex_valid && ex_mem_write}};
	assign data_sram_addr  = alu_res;
	assign data_sram_wdata = rt_fwd;

	// one start per divu, cleared as it leaves EX
	assign div_start = ex_valid && ex_is_divu && !div_issued;
	assign ex_ready  = !ex_is_divu || div_done;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			div_issued <= 1'b0;
		else if (ex_to_mem)
			div_issued <= 1'b0;
		else if (div_start)
			div_issued <= 1'b1;
	end

	divu_unit u_divu (
		.clk, .resetn, .start(div_start), .ack(ex_to_mem && ex_is_divu),
		.dividend(rs_fwd), .divisor(rt_fwd), .done(div_done),
		.quotient(div_quo), .remainder(div_rem)
	);

	// divu in MEM still has its result on the divider outputs
	assign hi_fwd = (mem_valid && mem_is_divu) ? div_rem : hi_q;
	assign lo_fwd = (mem_valid && mem_is_divu) ? div_quo : lo_q;

	always_comb
	begin
		case (ex_wb_sel)
			WB_HI:   ex_result = hi_fwd;
			WB_LO:   ex_result = lo_fwd;
			default: ex_result = alu_res;
		endcase
	end

	// EX/MEM
	always_ff @(posedge clk)
	begin
		if (ex_to_mem)
		begin
			mem_pc        <= ex_pc;
			mem_rd        <= ex_rd;
			mem_reg_write <= ex_reg_write;
			mem_is_divu   <= ex_is_divu;
			mem_wb_sel    <= ex_wb_sel;
			mem_result    <= ex_result;
		end
	end

	// load data arrives during MEM
	assign mem_wdata = (mem_wb_sel == WB_MEM) ? data_sram_rdata : mem_result;
	assign mem_wen   = mem_valid && mem_reg_write && (mem_rd != '0);

	always_ff @(posedge clk)
	begin
		if (mem_valid && mem_is_divu)
		begin
			hi_q <= div_rem;
			lo_q <= div_quo;
		end
	end

	// write-back trace, one cycle behind the regfile write
	always_ff @(posedge clk)
	begin
		if (!resetn)
			debug_wb_rf_wen <= '0;
		else
			debug_wb_rf_wen <= {4{mem_wen}};
	end

	always_ff @(posedge clk)
	begin
		if (mem_wen)
		begin
			debug_wb_pc       <= mem_pc;
			debug_wb_rf_wnum  <= mem_rd;
			debug_wb_rf_wdata <= mem_wdata;
		end
	end

endmodule

// File: rtl/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
	input  logic               clk,
	input  logic               resetn,
	input  logic               ex_ready,
	input  logic               redirect,
	input  cpu_isa_pkg::word_t redirect_pc,
	output logic               id_valid,
	output logic               ex_valid,
	output logic               mem_valid,
	output logic               id_to_ex,
	output logic               ex_to_mem,
	output cpu_isa_pkg::word_t id_pc,
	output cpu_isa_pkg::word_t fetch_addr
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	pipe_state_e state_q;
	logic        id_allowin;
	logic        ex_allowin;

	// MEM always drains, ID always ready
	assign ex_allowin = !ex_valid || ex_ready;
	assign id_allowin = !id_valid || ex_allowin;
	assign id_to_ex   = id_valid && ex_allowin;
	assign ex_to_mem  = ex_valid && ex_ready;

	// next word for ID
	// stalled fetch repeats id_pc so the SRAM hands back the same word
	always_comb
	begin
		if (state_q == PIPE_BOOT)
			fetch_addr = RESET_VECTOR;
		else if (redirect)
			fetch_addr = redirect_pc;
		else if (id_allowin)
			fetch_addr = id_pc + 32'd4;
		else
			fetch_addr = id_pc;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state_q   <= PIPE_BOOT;
			id_valid  <= 1'b0;
			ex_valid  <= 1'b0;
			mem_valid <= 1'b0;
		end
		else
		begin
			state_q <= PIPE_RUN;
			if (id_allowin)
				id_valid <= 1'b1;
			if (ex_allowin)
				ex_valid <= id_valid;
			mem_valid <= ex_to_mem;
		end
	end

	// pc of the word arriving from the SRAM
	always_ff @(posedge clk)
	begin
		if (id_allowin)
			id_pc <= fetch_addr;
	end

	// a redirecting branch holds a valid EX slot and leaves it that cycle
	a_redirect_moves: assert property (@(posedge clk) disable iff (!resetn)
		redirect |-> ex_to_mem);

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                   clk,
	input  cpu_isa_pkg::reg_addr_t rs_addr,
	input  cpu_isa_pkg::reg_addr_t rt_addr,
	input  cpu_isa_pkg::reg_addr_t w_addr,
	input  logic                   w_en,
	input  cpu_isa_pkg::word_t     w_data,
	output cpu_isa_pkg::word_t     rs_data,
	output cpu_isa_pkg::word_t     rt_data
);
	import cpu_isa_pkg::*;

	// r0 has no storage
	word_t regs [1:(1 << REG_ADDR_W) - 1];

	always_ff @(posedge clk)
	begin
		if (w_en)
			regs[w_addr] <= w_data;
	end

	// asynchronous read, r0 reads as zero
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

	// MEM stage filters r0 destinations before the write port
	a_no_r0_write: assert property (@(posedge clk) w_en |-> w_addr != '0);

endmodule

// File: verif/tb_mycpu.sv
`timescale 1ns/1ps

module tb_mycpu;
	import cpu_isa_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int SEED         = 74100;
	localparam int PROG_MAX     = 128;
	localparam int DMEM_WORDS   = 64;
	localparam int DRAIN_CYCLES = 20;
	localparam int NUM_GROUPS   = 6;

	logic       clk = 1'b0;
	logic       resetn;
	word_t      inst_sram_addr, inst_sram_rdata;
	logic       data_sram_en;
	logic [3:0] data_sram_wen;
	word_t      data_sram_addr, data_sram_wdata, data_sram_rdata;
	word_t      debug_wb_pc, debug_wb_rf_wdata;
	logic [3:0] debug_wb_rf_wen;
	reg_addr_t  debug_wb_rf_wnum;

	// program image and expected write-back events
	word_t     prog [0:PROG_MAX-1];
	int        prog_len = 0;
	int        cur_grp = 0;
	logic      built = 1'b0;
	word_t     ev_pc[$], ev_val[$], st_addr[$], st_data[$];
	reg_addr_t ev_rd[$];
	int        ev_grp[$];

	// isa reference state
	word_t ref_rf [0:31];
	word_t ref_mem [0:DMEM_WORDS-1];
	word_t ref_hi, ref_lo;
	word_t lcg_state = SEED;

	// data SRAM contents and sampled request
	word_t      dmem [0:DMEM_WORDS-1];
	word_t      i_addr_q, d_addr_q, d_wdata_q;
	logic       d_en_q;
	logic [3:0] d_wen_q;

	int checks = 0;
	int errors = 0;
	int grp_err [0:NUM_GROUPS-1];
	int grp_cnt [0:NUM_GROUPS-1];

	mycpu_top dut_i (
		.resetn, .clk, .inst_sram_addr, .inst_sram_rdata, .data_sram_en, .data_sram_wen,
		.data_sram_addr, .data_sram_wdata, .data_sram_rdata, .debug_wb_pc,
		.debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper half has the better lcg bits
	function automatic logic [15:0] rand16();
		word_t r;
		r = next_random();
		return r[31:16];
	endfunction

	// fill depends on every address bit of the model
	function automatic word_t fill_word(input int idx);
		word_t a;
		a = idx * 4;
		return {~a[15:0], a[15:0]};
	endfunction

	function automatic word_t enc_r(input funct_e fn, input reg_addr_t rd, rs, rt,
		input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t enc_i(input opcode_e op, input reg_addr_t rt, rs,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic string group_name(input int g);
		case (g)
			0: return "register ops";
			1: return "immediate ops";
			2: return "dependent chain";
			3: return "store and load";
			4: return "branches and jump";
			default: return "divide and hi/lo";
		endcase
	endfunction

	// out of range or unknown address reads as a nop
	function automatic word_t fetch_word(input word_t addr);
		word_t idx;
		idx = (addr - RESET_VECTOR) >> 2;
		if (idx < prog_len)
			return prog[idx];
		else
			return 32'h0;
	endfunction

	// one instruction, plus its write-back if it has one
	task automatic add_row(input word_t inst, input logic wr, input reg_addr_t rd,
		input word_t val);
		prog[prog_len] = inst;
		if (wr && rd != 0)
		begin
			ev_pc.push_back(RESET_VECTOR + 4 * prog_len);
			ev_rd.push_back(rd);
			ev_val.push_back(val);
			ev_grp.push_back(cur_grp);
			ref_rf[rd] = val;
		end
		prog_len++;
	endtask

	task automatic r_op(input funct_e fn, input reg_addr_t rd, rs, rt, input logic [4:0] sh);
		word_t a, b, v;
		a = ref_rf[rs];
		b = ref_rf[rt];
		case (fn)
			FN_ADDU: v = a + b;
			FN_SUBU: v = a - b;
			FN_AND:  v = a & b;
			FN_OR:   v = a | b;
			FN_XOR:  v = a ^ b;
			FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			FN_SLTU: v = (a < b) ? 32'd1 : 32'd0;
			FN_SLL:  v = b << sh;
			default: v = b >> sh;
		endcase
		add_row(enc_r(fn, rd, rs, rt, sh), 1'b1, rd, v);
	endtask

	task automatic i_op(input opcode_e op, input reg_addr_t rt, rs, input logic [15:0] imm);
		word_t a, se, v;
		a  = ref_rf[rs];
		se = {{16{imm[15]}}, imm};
		case (op)
			OP_ADDIU: v = a + se;
			OP_SLTI:  v = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
			OP_ANDI:  v = a & {16'h0, imm};
			OP_ORI:   v = a | {16'h0, imm};
			default:  v = {imm, 16'h0};
		endcase
		add_row(enc_i(op, rt, rs, imm), 1'b1, rt, v);
	endtask

	// lui/ori pair
	task automatic load_const(input reg_addr_t rd, input word_t val);
		i_op(OP_LUI, rd, 0, val[31:16]);
		i_op(OP_ORI, rd, rd, val[15:0]);
	endtask

	task automatic store(input reg_addr_t rt, base, input logic [15:0] off);
		word_t addr;
		addr = ref_rf[base] + {{16{off[15]}}, off};
		ref_mem[addr[7:2]] = ref_rf[rt];
		st_addr.push_back(addr);
		st_data.push_back(ref_rf[rt]);
		add_row(enc_i(OP_SW, rt, base, off), 1'b0, 0, 0);
	endtask

	task automatic load(input reg_addr_t rt, base, input logic [15:0] off);
		word_t addr;
		addr = ref_rf[base] + {{16{off[15]}}, off};
		add_row(enc_i(OP_LW, rt, base, off), 1'b1, rt, ref_mem[addr[7:2]]);
	endtask

	// branch over two rows, the delay slot always retires
	task automatic branch(input opcode_e op, input reg_addr_t rs, rt);
		word_t pc, target;
		logic  taken;
		pc     = RESET_VECTOR + 4 * prog_len;
		target = pc + 32'd16;
		if (op == OP_J)
		begin
			taken = 1'b1;
			add_row({OP_J, target[27:2]}, 1'b0, 0, 0);
		end
		else
		begin
			taken = (op == OP_BEQ) == (ref_rf[rs] == ref_rf[rt]);
			add_row(enc_i(op, rt, rs, 16'd3), 1'b0, 0, 0);
		end
		i_op(OP_ADDIU, 30, 0, rand16());
		repeat (2)
		begin
			// skipped rows would show up as writes to r9
			if (taken)
				add_row(enc_i(OP_ADDIU, 9, 0, 16'h0bad), 1'b0, 0, 0);
			else
				i_op(OP_ADDIU, 31, 0, rand16());
		end
	endtask

	task automatic divide(input reg_addr_t rs, rt);
		word_t a, b;
		a = ref_rf[rs];
		b = ref_rf[rt];
		ref_lo = (b == 0) ? 32'hffff_ffff : a / b;
		ref_hi = (b == 0) ? a : a % b;
		add_row(enc_r(FN_DIVU, 0, rs, rt, 0), 1'b0, 0, 0);
	endtask

	task automatic move_from(input funct_e fn, input reg_addr_t rd);
		add_row(enc_r(fn, rd, 0, 0, 0), 1'b1, rd, (fn == FN_MFHI) ? ref_hi : ref_lo);
	endtask

	task automatic build_program();
		word_t pc;
		for (int i = 0; i < 32; i++)
			ref_rf[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
		begin
			ref_mem[i] = fill_word(i);
			dmem[i]    = fill_word(i);
		end
		for (int g = 0; g < NUM_GROUPS; g++)
		begin
			grp_err[g] = 0;
			grp_cnt[g] = 0;
		end
		cur_grp = 0;
		for (int r = 1; r <= 4; r++)
			load_const(r, next_random());
		r_op(FN_ADDU, 11, 1, 2, 0);
		r_op(FN_SUBU, 12, 1, 3, 0);
		r_op(FN_AND, 13, 2, 4, 0);
		r_op(FN_OR, 14, 3, 4, 0);
		r_op(FN_XOR, 15, 1, 4, 0);
		r_op(FN_SLT, 16, 1, 2, 0);
		r_op(FN_SLTU, 17, 3, 2, 0);
		r_op(FN_SLL, 18, 0, 4, 5'(rand16()));
		r_op(FN_SRL, 19, 0, 3, 5'(rand16()));
		cur_grp = 1;
		i_op(OP_ADDIU, 20, 1, rand16());
		i_op(OP_ADDIU, 21, 2, 16'hfff0);
		load_const(5, 32'hffff_fff0);
		i_op(OP_SLTI, 22, 5, 16'h0001);
		i_op(OP_SLTI, 23, 1, 16'h8000);
		i_op(OP_ANDI, 24, 3, rand16());
		i_op(OP_ORI, 25, 4, rand16());
		i_op(OP_LUI, 26, 0, rand16());
		// each row reads the one just before it
		cur_grp = 2;
		r_op(FN_ADDU, 6, 1, 2, 0);
		r_op(FN_SUBU, 6, 6, 3, 0);
		r_op(FN_XOR, 7, 6, 1, 0);
		r_op(FN_ADDU, 7, 7, 7, 0);
		r_op(FN_SLL, 8, 0, 7, 5'd3);
		r_op(FN_OR, 8, 8, 6, 0);
		i_op(OP_ADDIU, 8, 8, 16'h8001);
		cur_grp = 3;
		i_op(OP_ADDIU, 10, 0, 16'h0100);
		store(1, 10, 16'h0000);
		load(26, 10, 16'h0000);
		store(2, 10, 16'h0008);
		load(27, 10, 16'h0008);
		r_op(FN_ADDU, 28, 27, 26, 0);
		load(29, 10, 16'h0040);
		cur_grp = 4;
		branch(OP_BEQ, 1, 1);
		branch(OP_BEQ, 1, 2);
		branch(OP_BNE, 1, 2);
		branch(OP_BNE, 3, 3);
		branch(OP_J, 0, 0);
		cur_grp = 5;
		i_op(OP_ADDIU, 12, 0, (rand16() & 16'h7fff) | 16'h0001);
		divide(2, 12);
		move_from(FN_MFHI, 13);
		move_from(FN_MFLO, 14);
		i_op(OP_ADDIU, 15, 14, 16'h0001);
		// divide by zero, then hi/lo read after an unrelated row
		divide(1, 0);
		i_op(OP_ADDIU, 18, 0, 16'h0005);
		move_from(FN_MFLO, 16);
		move_from(FN_MFHI, 17);
		divide(3, 4);
		move_from(FN_MFLO, 19);
		move_from(FN_MFHI, 20);
		// park in a jump to itself with a nop delay slot
		pc = RESET_VECTOR + 4 * prog_len;
		add_row({OP_J, pc[27:2]}, 1'b0, 0, 0);
		add_row(32'h0, 1'b0, 0, 0);
	endtask

	task automatic compare(input string name, input word_t got, exp, input int grp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
			grp_err[grp]++;
		end
	endtask

	task automatic store_word(input logic [3:0] wen, input word_t addr, data);
		checks++;
		compare("data_sram_wen", word_t'(wen), 32'hf, 3);
		assert (st_addr.size() != 0)
		else
		begin
			$display("store to %h with data %h that the program never issued", addr, data);
			errors++;
			grp_err[3]++;
		end
		if (st_addr.size() != 0)
		begin
			compare("data_sram_addr", addr, st_addr.pop_front(), 3);
			compare("data_sram_wdata", data, st_data.pop_front(), 3);
		end
		dmem[addr[7:2]] = data;
	endtask

	// requests are stable mid cycle
	always @(negedge clk)
	begin
		i_addr_q  = inst_sram_addr;
		d_en_q    = data_sram_en;
		d_wen_q   = data_sram_wen;
		d_addr_q  = data_sram_addr;
		d_wdata_q = data_sram_wdata;
	end

	// both SRAMs answer one cycle after the request
	always @(posedge clk)
	begin
		#1;
		inst_sram_rdata = fetch_word(i_addr_q);
		if (d_en_q === 1'b1 && d_wen_q !== 4'h0)
			store_word(d_wen_q, d_addr_q, d_wdata_q);
		else if (d_en_q === 1'b1)
			data_sram_rdata = dmem[d_addr_q[7:2]];
	end

	// budget covers a full divide for every row
	initial
	begin
		wait (built);
		repeat (RESET_CYCLES + prog_len * (DIV_CYCLES + 4)) @(posedge clk);
		$display("timeout: write-back trace stalled before the program finished");
		$display("sim failed");
		$finish;
	end

	initial
	begin
		resetn          = 1'b0;
		inst_sram_rdata = '0;
		data_sram_rdata = '0;
		build_program();
		built = 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		// outputs sit in their reset state late in reset
		@(negedge clk);
		compare("inst_sram_addr", inst_sram_addr, RESET_VECTOR, 0);
		compare("data_sram_en", word_t'(data_sram_en), 32'h0, 0);
		compare("data_sram_wen", word_t'(data_sram_wen), 32'h0, 0);
		compare("debug_wb_rf_wen", word_t'(debug_wb_rf_wen), 32'h0, 0);
		@(posedge clk);
		#1;
		resetn = 1'b1;
		for (int k = 0; k < ev_pc.size(); k++)
		begin
			@(negedge clk);
			while (debug_wb_rf_wen === 4'h0)
				@(negedge clk);
			compare("debug_wb_rf_wen", word_t'(debug_wb_rf_wen), 32'hf, ev_grp[k]);
			compare("debug_wb_pc", debug_wb_pc, ev_pc[k], ev_grp[k]);
			compare("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum), word_t'(ev_rd[k]), ev_grp[k]);
			compare("debug_wb_rf_wdata", debug_wb_rf_wdata, ev_val[k], ev_grp[k]);
			grp_cnt[ev_grp[k]]++;
			if (k == ev_pc.size() - 1 || ev_grp[k + 1] != ev_grp[k])
				$display("test %0d %s: %0d write-backs, %0d errors", ev_grp[k],
					group_name(ev_grp[k]), grp_cnt[ev_grp[k]], grp_err[ev_grp[k]]);
		end
		// nothing may retire once the program sits in its loop
		repeat (DRAIN_CYCLES)
		begin
			@(negedge clk);
			checks++;
			assert (debug_wb_rf_wen === 4'h0)
			else
			begin
				$display("extra write-back of r%0d at pc %h after the last expected one",
					debug_wb_rf_wnum, debug_wb_pc);
				errors++;
			end
		end
		checks++;
		assert (st_addr.size() == 0)
		else
		begin
			$display("%0d expected stores never reached the data SRAM", st_addr.size());
			errors++;
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
